// File: design/rv_decode_pkg.sv
//////////////////////////////
// RV32I decode constants
// Opcodes, funct3 and ALU control codes
//////////////////////////////

package rv_decode_pkg;

	// Datapath and register file sizes
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int ALU_CTRL_W = 4;

	// Major opcodes, instr[6:0]
	localparam logic [6:0] OPC_R      = 7'b0110011; // Register-register ALU
	localparam logic [6:0] OPC_I      = 7'b0010011; // Register-immediate ALU
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	// Branch conditions, funct3
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// ALU operations, funct3 of OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000; // funct7[5] picks SUB on R-type
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101; // funct7[5] picks SRA
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// ALU control codes handed to EX
	localparam logic [ALU_CTRL_W-1:0] ALU_ADD   = 4'd0;
	localparam logic [ALU_CTRL_W-1:0] ALU_SUB   = 4'd1;
	localparam logic [ALU_CTRL_W-1:0] ALU_SLL   = 4'd2;
	localparam logic [ALU_CTRL_W-1:0] ALU_SLT   = 4'd3;
	localparam logic [ALU_CTRL_W-1:0] ALU_SLTU  = 4'd4;
	localparam logic [ALU_CTRL_W-1:0] ALU_XOR   = 4'd5;
	localparam logic [ALU_CTRL_W-1:0] ALU_SRL   = 4'd6;
	localparam logic [ALU_CTRL_W-1:0] ALU_SRA   = 4'd7;
	localparam logic [ALU_CTRL_W-1:0] ALU_OR    = 4'd8;
	localparam logic [ALU_CTRL_W-1:0] ALU_AND   = 4'd9;
	localparam logic [ALU_CTRL_W-1:0] ALU_PASSB = 4'd10; // Operand B straight through, LUI

	// addi x0, x0, 0
	localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

endpackage

// File: design/reg_file.sv
//////////////////////////////
// Register file, 32 x XLEN
// Two comb read ports, one write port
//////////////////////////////
`timescale 1ns/10ps

module reg_file import rv_decode_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_re,         // Read enable from decoder
	input  logic [REG_ADDR_W-1:0] i_rs1,
	input  logic [REG_ADDR_W-1:0] i_rs2,
	input  logic                  i_wr,         // Write strobe from WB
	input  logic [REG_ADDR_W-1:0] i_rd,         // WB destination
	input  logic [XLEN-1:0]       i_write_data,
	output logic [XLEN-1:0]       o_read_data1,
	output logic [XLEN-1:0]       o_read_data2
);

	logic [XLEN-1:0] regs [NUM_REGS]; // Architectural registers

	// Write port, x0 never written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr && (i_rd != '0)) begin
			regs[i_rd] <= i_write_data;
		end
	end

	// Reads are comb, no bypass of a same-cycle write
	always_comb begin
		o_read_data1 = '0;
		o_read_data2 = '0;
		if (i_re && (i_rs1 != '0)) begin
			o_read_data1 = regs[i_rs1];
		end
		if (i_re && (i_rs2 != '0)) begin
			o_read_data2 = regs[i_rs2];
		end
	end

	// x0 storage and its read value stay zero across a write aimed at x0
	a_x0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(i_wr && (i_rd == '0)) |=> ($stable(regs[0]) && (regs[0] == '0)))
		else $error("x0 changed after a write to x0");

endmodule

// File: design/instr_decoder.sv
//////////////////////////////
// RV32I instruction decoder
// Fields, immediate, ALU code, flags
//////////////////////////////
`timescale 1ns/10ps

module instr_decoder import rv_decode_pkg::*; (
	input  logic [XLEN-1:0]       i_instr,
	output logic [REG_ADDR_W-1:0] o_rs1,
	output logic [REG_ADDR_W-1:0] o_rs2,
	output logic [REG_ADDR_W-1:0] o_rd,
	output logic [6:0]            o_opcode,
	output logic [2:0]            o_func3,
	output logic [XLEN-1:0]       o_imm,      // Sign-extended immediate
	output logic [ALU_CTRL_W-1:0] o_alu_ctrl,
	output logic                  o_re,       // Register file read enable
	output logic                  o_is_branch,
	output logic                  o_is_jal,
	output logic                  o_is_jalr
);

	logic is_f7b5; // funct7 bit 5, SUB and SRA select

	// Fixed field positions
	assign o_rs1    = i_instr[19:15];
	assign o_rs2    = i_instr[24:20];
	assign o_rd     = i_instr[11:7];
	assign o_opcode = i_instr[6:0];
	assign o_func3  = i_instr[14:12];
	assign is_f7b5  = i_instr[30];

	// Class flags
	assign o_is_branch = (o_opcode == OPC_BRANCH);
	assign o_is_jal    = (o_opcode == OPC_JAL);
	assign o_is_jalr   = (o_opcode == OPC_JALR);

	// No source registers on LUI, AUIPC and JAL
	assign o_re = !((o_opcode == OPC_LUI) || (o_opcode == OPC_AUIPC) || o_is_jal);

	// Immediate format picked by opcode
	always_comb begin
		unique case (o_opcode)
			OPC_I, OPC_LOAD, OPC_JALR: // I-type
				o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
			OPC_STORE: // S-type
				o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
			OPC_BRANCH: // B-type, bit 0 implied zero
				o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
					i_instr[30:25], i_instr[11:8], 1'b0};
			OPC_LUI, OPC_AUIPC:
				o_imm = {i_instr[31:12], 12'b0}; // U-type, upper 20 bits
			OPC_JAL: // J-type
				o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
					i_instr[20], i_instr[30:21], 1'b0};
			default:
				o_imm = '0; // R-type has no immediate
		endcase
	end

	// ALU control
	always_comb begin
		o_alu_ctrl = ALU_ADD; // Loads, stores, jumps, AUIPC
		case (o_opcode)
			OPC_R, OPC_I: begin
				case (o_func3)
					F3_ADD_SUB: begin
						// Only R-type has SUB, ADDI keeps imm bit 30
						if ((o_opcode == OPC_R) && is_f7b5) begin
							o_alu_ctrl = ALU_SUB;
						end else begin
							o_alu_ctrl = ALU_ADD;
						end
					end
					F3_SLL:  o_alu_ctrl = ALU_SLL;
					F3_SLT:  o_alu_ctrl = ALU_SLT;
					F3_SLTU: o_alu_ctrl = ALU_SLTU;
					F3_XOR:  o_alu_ctrl = ALU_XOR;
					F3_SRL_SRA: begin
						o_alu_ctrl = is_f7b5 ? ALU_SRA : ALU_SRL; // Same bit on SRAI
					end
					F3_OR:   o_alu_ctrl = ALU_OR;
					F3_AND:  o_alu_ctrl = ALU_AND;
					default: o_alu_ctrl = ALU_ADD;
				endcase
			end
			OPC_BRANCH: o_alu_ctrl = ALU_SUB;   // Compare by subtraction in EX
			OPC_LUI:    o_alu_ctrl = ALU_PASSB; // Immediate straight through
			default:    o_alu_ctrl = ALU_ADD;
		endcase
	end

endmodule

// File: design/branch_resolve.sv
//////////////////////////////
// Branch and jump resolution
// Taken decision and target PC
//////////////////////////////
`timescale 1ns/10ps

module branch_resolve import rv_decode_pkg::*; (
	input  logic [XLEN-1:0] i_rs1_data, // Forwarded operand A
	input  logic [XLEN-1:0] i_rs2_data, // Forwarded operand B
	input  logic [XLEN-1:0] i_pc,
	input  logic [XLEN-1:0] i_imm,
	input  logic [2:0]      i_func3,
	input  logic            i_is_branch,
	input  logic            i_is_jal,
	input  logic            i_is_jalr,
	output logic            o_taken,
	output logic [XLEN-1:0] o_target
);

	logic is_eq;
	logic is_lt;  // Signed less-than
	logic is_ltu; // Unsigned less-than
	logic is_cond;
	logic [XLEN-1:0] is_jalr_sum;

	assign is_eq  = (i_rs1_data == i_rs2_data);
	assign is_lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
	assign is_ltu = (i_rs1_data < i_rs2_data);

	// Condition per funct3
	always_comb begin
		case (i_func3)
			F3_BEQ:  is_cond = is_eq;
			F3_BNE:  is_cond = !is_eq;
			F3_BLT:  is_cond = is_lt;
			F3_BGE:  is_cond = !is_lt;
			F3_BLTU: is_cond = is_ltu;
			F3_BGEU: is_cond = !is_ltu;
			default: is_cond = 1'b0; // Reserved encodings never branch
		endcase
	end

	// Jumps always redirect
	assign o_taken = i_is_jal || i_is_jalr || (i_is_branch && is_cond);

	// JALR is register relative and clears bit 0 while others are PC relative
	assign is_jalr_sum = i_rs1_data + i_imm;
	assign o_target    = i_is_jalr ? {is_jalr_sum[XLEN-1:1], 1'b0} : (i_pc + i_imm);

	// Decoder flags are one-hot by opcode so a redirect sees exactly one of them
	always_comb begin
		if (o_taken) begin
			assert ($onehot({i_is_branch, i_is_jal, i_is_jalr}))
				else $error("Taken without exactly one branch or jump flag");
		end
	end

endmodule

// File: design/decode_stage.sv
//////////////////////////////
// RV32I decode stage
// Reg read, decode, branch, ID/EX reg
//////////////////////////////
`timescale 1ns/10ps

module decode_stage import rv_decode_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	// From fetch
	input  logic [XLEN-1:0]       i_instr,
	input  logic [XLEN-1:0]       i_pc,
	// From writeback
	input  logic                  i_wr,
	input  logic [REG_ADDR_W-1:0] i_wr_rd,
	input  logic [XLEN-1:0]       i_write_data,
	// Pipeline control
	input  logic                  i_prediction, // Fetch predicted taken
	input  logic                  i_stall,
	input  logic                  i_fwd_rs1,    // Branch operand A from EX
	input  logic                  i_fwd_rs2,    // Branch operand B from EX
	input  logic [XLEN-1:0]       i_ex_result,
	// To execute
	output logic [XLEN-1:0]       o_rs1_data,
	output logic [XLEN-1:0]       o_rs2_data,
	output logic [XLEN-1:0]       o_imm_data,
	output logic [6:0]            o_opcode,
	output logic [2:0]            o_func3,
	output logic [ALU_CTRL_W-1:0] o_alu_ctrl,
	output logic [XLEN-1:0]       o_pc,
	output logic [REG_ADDR_W-1:0] o_rs1,
	output logic [REG_ADDR_W-1:0] o_rs2,
	output logic [REG_ADDR_W-1:0] o_rd,
	// Back to fetch
	output logic [XLEN-1:0]       o_branch_pc,
	output logic                  o_flush,
	output logic                  o_stall
);

	// Decoder outputs
	logic [REG_ADDR_W-1:0] is_rs1, is_rs2, is_rd;
	logic [6:0]            is_opcode;
	logic [2:0]            is_func3;
	logic [XLEN-1:0]       is_imm;
	logic [ALU_CTRL_W-1:0] is_alu_ctrl;
	logic                  is_re;
	logic                  is_branch, is_jal, is_jalr;
	// Operands
	logic [XLEN-1:0]       is_rs1_data, is_rs2_data; // Straight from reg file
	logic [XLEN-1:0]       is_rs1_d, is_rs2_d;       // After EX forwarding
	logic                  is_taken;

	instr_decoder u_instr_decoder (
		.i_instr     (i_instr),
		.o_rs1       (is_rs1),
		.o_rs2       (is_rs2),
		.o_rd        (is_rd),
		.o_opcode    (is_opcode),
		.o_func3     (is_func3),
		.o_imm       (is_imm),
		.o_alu_ctrl  (is_alu_ctrl),
		.o_re        (is_re),
		.o_is_branch (is_branch),
		.o_is_jal    (is_jal),
		.o_is_jalr   (is_jalr)
	);

	reg_file u_reg_file (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_re         (is_re),
		.i_rs1        (is_rs1),
		.i_rs2        (is_rs2),
		.i_wr         (i_wr),
		.i_rd         (i_wr_rd),
		.i_write_data (i_write_data),
		.o_read_data1 (is_rs1_data),
		.o_read_data2 (is_rs2_data)
	);

	// Forwarding only feeds the comparator
	assign is_rs1_d = i_fwd_rs1 ? i_ex_result : is_rs1_data;
	assign is_rs2_d = i_fwd_rs2 ? i_ex_result : is_rs2_data;

	branch_resolve u_branch_resolve (
		.i_rs1_data  (is_rs1_d),
		.i_rs2_data  (is_rs2_d),
		.i_pc        (i_pc),
		.i_imm       (is_imm),
		.i_func3     (is_func3),
		.i_is_branch (is_branch),
		.i_is_jal    (is_jal),
		.i_is_jalr   (is_jalr),
		.o_taken     (is_taken),
		.o_target    (o_branch_pc)
	);

	assign o_flush = i_prediction ^ is_taken; // Misprediction either way
	assign o_stall = i_stall;

	// ID/EX register, holds on stall, bubble on flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_rs1_data <= '0;
			o_rs2_data <= '0;
			o_imm_data <= '0;
			o_opcode   <= INSTR_NOP[6:0];
			o_func3    <= INSTR_NOP[14:12];
			o_alu_ctrl <= ALU_ADD;
			o_pc       <= '0;
			o_rs1      <= INSTR_NOP[19:15];
			o_rs2      <= INSTR_NOP[24:20];
			o_rd       <= INSTR_NOP[11:7];
		end else if (!i_stall) begin
			if (o_flush) begin // Same bubble as reset
				o_rs1_data <= '0;
				o_rs2_data <= '0;
				o_imm_data <= '0;
				o_opcode   <= INSTR_NOP[6:0];
				o_func3    <= INSTR_NOP[14:12];
				o_alu_ctrl <= ALU_ADD;
				o_pc       <= '0;
				o_rs1      <= INSTR_NOP[19:15];
				o_rs2      <= INSTR_NOP[24:20];
				o_rd       <= INSTR_NOP[11:7];
			end else begin
				o_rs1_data <= is_rs1_data; // Unforwarded, EX resolves its own hazards
				o_rs2_data <= is_rs2_data;
				o_imm_data <= is_imm;
				o_opcode   <= is_opcode;
				o_func3    <= is_func3;
				o_alu_ctrl <= is_alu_ctrl;
				o_pc       <= i_pc;
				o_rs1      <= is_rs1;
				o_rs2      <= is_rs2;
				o_rd       <= is_rd;
			end
		end
	end

	// Fetch must present no redirecting instruction or prediction during reset
	a_no_flush_in_reset: assert property (@(posedge clk) !rst_n |-> !o_flush)
		else $error("Flush raised during reset");

endmodule

// File: tb/clk_rst_gen.sv
//////////////////////////////
// Testbench clock and reset
// 8 ns clock, reset low 3 cycles
//////////////////////////////
`timescale 1ns/10ps

module clk_rst_gen (
	output logic o_clk,
	output logic o_rst_n
);

	// Half period of 4 ns
	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	// Release on the third rising edge
	initial begin
		o_rst_n = 1'b0;
		repeat (3) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

// File: tb/tb_decode_stage.sv
//////////////////////////////
// Decode stage testbench
// Preload, table of instructions, checks
//////////////////////////////
`timescale 1ns/10ps

module tb_decode_stage import rv_decode_pkg::*; ();

	typedef struct packed {
		logic [XLEN-1:0]       instr, pc, ex, imm, tgt;
		logic [ALU_CTRL_W-1:0] alu;
		logic                  pred, stall, fwd1, fwd2; // Driven controls
		logic                  re, flush, tgt_chk;      // Expected read enable and flush
	} entry_t;

	logic clk, rst_n;
	// DUT inputs
	logic [XLEN-1:0]       instr, pc, write_data, ex_result;
	logic                  wr, prediction, stall, fwd_rs1, fwd_rs2;
	logic [REG_ADDR_W-1:0] wr_rd;
	// ID/EX outputs
	logic [XLEN-1:0]       rs1_data_q, rs2_data_q, imm_q, pc_q;
	logic [6:0]            opcode_q;
	logic [2:0]            func3_q;
	logic [ALU_CTRL_W-1:0] alu_q;
	logic [REG_ADDR_W-1:0] rs1_q, rs2_q, rd_q;
	// Back to fetch
	logic [XLEN-1:0]       branch_pc;
	logic                  flush, stall_out;
	// Expected ID/EX contents
	logic [XLEN-1:0]       exp_rs1_data, exp_rs2_data, exp_imm, exp_pc;
	logic [6:0]            exp_opcode;
	logic [2:0]            exp_func3;
	logic [ALU_CTRL_W-1:0] exp_alu;
	logic [REG_ADDR_W-1:0] exp_rs1, exp_rs2, exp_rd;

	logic [XLEN-1:0] model [NUM_REGS]; // What the preload wrote
	logic [XLEN-1:0] val;
	entry_t          tbl[$];
	int              errors, cycles, max_cycles;

	clk_rst_gen u_clk_rst_gen (.o_clk(clk), .o_rst_n(rst_n));

	decode_stage i_dut (
		.clk(clk), .rst_n(rst_n), .i_instr(instr), .i_pc(pc),
		.i_wr(wr), .i_wr_rd(wr_rd), .i_write_data(write_data),
		.i_prediction(prediction), .i_stall(stall), .i_fwd_rs1(fwd_rs1), .i_fwd_rs2(fwd_rs2),
		.i_ex_result(ex_result),
		.o_rs1_data(rs1_data_q), .o_rs2_data(rs2_data_q), .o_imm_data(imm_q),
		.o_opcode(opcode_q), .o_func3(func3_q), .o_alu_ctrl(alu_q), .o_pc(pc_q),
		.o_rs1(rs1_q), .o_rs2(rs2_q), .o_rd(rd_q),
		.o_branch_pc(branch_pc), .o_flush(flush), .o_stall(stall_out)
	);

	// RV32I encoders taking immediates at their full width
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_R};
	endfunction
	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction
	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction
	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction
	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction
	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic compare(input logic [31:0] act, input logic [31:0] exp, input string what);
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, act, exp);
		end
	endtask

	task automatic add_entry(input logic [31:0] word, pc_v, input logic [3:0] ctl,
		input logic [31:0] ex, imm, input logic [3:0] alu, input logic [2:0] chk,
		input logic [31:0] tgt);
		entry_t e;
		e.instr = word;
		e.pc    = pc_v;
		e.ex    = ex;
		e.imm   = imm;
		e.alu   = alu;
		e.tgt   = tgt;
		{e.pred, e.stall, e.fwd1, e.fwd2} = ctl;
		{e.re, e.flush, e.tgt_chk}        = chk;
		tbl.push_back(e);
	endtask

	// Fixed operands x1 = x5 = INT_MIN, x2 = INT_MAX, x3 = -1, x4 = 1 and x6 = 0x1003
	task automatic build_table();
		// instr, pc, {pred stall fwd1 fwd2}, ex, imm, alu, {re flush tgt_chk}, tgt
		add_entry(enc_r(7'h00, 5'd8, 5'd7, F3_ADD_SUB, 5'd10), 'h100, 4'b0000,
			0, 0, ALU_ADD, 3'b100, 0);
		add_entry(enc_r(7'h20, 5'd10, 5'd9, F3_ADD_SUB, 5'd11), 'h104, 4'b0000,
			0, 0, ALU_SUB, 3'b100, 0);
		add_entry(enc_r(7'h20, 5'd31, 5'd0, F3_SRL_SRA, 5'd12), 'h108, 4'b0000,
			0, 0, ALU_SRA, 3'b100, 0);
		add_entry(enc_r(7'h00, 5'd2, 5'd1, F3_SLTU, 5'd13), 'h10C, 4'b0000,
			0, 0, ALU_SLTU, 3'b100, 0);
		add_entry(enc_i(12'hFFF, 5'd15, F3_ADD_SUB, 5'd14, OPC_I), 'h110, 4'b0000,
			0, -1, ALU_ADD, 3'b100, 0);
		add_entry(enc_i(12'h403, 5'd17, F3_SRL_SRA, 5'd16, OPC_I), 'h114, 4'b0000,
			0, 'h403, ALU_SRA, 3'b100, 0);
		add_entry(enc_i(12'h7FF, 5'd19, F3_XOR, 5'd18, OPC_I), 'h118, 4'b0000,
			0, 'h7FF, ALU_XOR, 3'b100, 0);
		add_entry(enc_i(12'h800, 5'd21, 3'd2, 5'd20, OPC_LOAD), 'h11C, 4'b0000,
			0, -2048, ALU_ADD, 3'b100, 0);
		add_entry(enc_s(12'd20, 5'd22, 5'd23, 3'd2), 'h120, 4'b0000,
			0, 20, ALU_ADD, 3'b100, 0);
		add_entry(enc_u(20'hABCDE, 5'd24, OPC_LUI), 'h124, 4'b0000,
			0, 'hABCD_E000, ALU_PASSB, 3'b000, 0);
		add_entry(enc_u(20'h80000, 5'd25, OPC_AUIPC), 'h128, 4'b0000,
			0, 'h8000_0000, ALU_ADD, 3'b000, 0);
		add_entry(enc_j(21'h1FFFF8, 5'd1), 'h12C, 4'b1000,
			0, -8, ALU_ADD, 3'b001, 'h124);
		add_entry(enc_i(12'd4, 5'd6, 3'd0, 5'd0, OPC_JALR), 'h130, 4'b1000,
			0, 4, ALU_ADD, 3'b101, 'h1006);
		add_entry(enc_i(12'hFFE, 5'd6, 3'd0, 5'd0, OPC_JALR), 'h134, 4'b0000,
			0, -2, ALU_ADD, 3'b111, 'h1000);
		add_entry(enc_b(13'd16, 5'd5, 5'd1, F3_BEQ), 'h138, 4'b1000,
			0, 16, ALU_SUB, 3'b101, 'h148);
		add_entry(enc_b(13'd16, 5'd5, 5'd1, F3_BNE), 'h13C, 4'b1000,
			0, 16, ALU_SUB, 3'b111, 'h14C);
		add_entry(enc_b(13'h1FF0, 5'd2, 5'd1, F3_BLT), 'h140, 4'b0000,
			0, -16, ALU_SUB, 3'b111, 'h130);
		add_entry(enc_b(13'd16, 5'd4, 5'd3, F3_BGE), 'h144, 4'b0000,
			0, 16, ALU_SUB, 3'b101, 'h154);
		add_entry(enc_b(13'd16, 5'd2, 5'd1, F3_BLTU), 'h148, 4'b0000,
			0, 16, ALU_SUB, 3'b101, 'h158);
		add_entry(enc_b(13'h0FFE, 5'd4, 5'd3, F3_BGEU), 'h14C, 4'b1000,
			0, 'hFFE, ALU_SUB, 3'b101, 'h114A);
		add_entry(enc_b(13'h1FF0, 5'd1, 5'd2, F3_BGE), 'h150, 4'b1000,
			0, -16, ALU_SUB, 3'b101, 'h140);
		// EX result replaces one comparator operand
		add_entry(enc_b(13'd16, 5'd5, 5'd1, F3_BEQ), 'h154, 4'b1010,
			0, 16, ALU_SUB, 3'b111, 'h164);
		add_entry(enc_b(13'd16, 5'd4, 5'd2, F3_BLT), 'h158, 4'b1010,
			0, 16, ALU_SUB, 3'b101, 'h168);
		add_entry(enc_b(13'd16, 5'd4, 5'd3, F3_BNE), 'h15C, 4'b0001,
			-1, 16, ALU_SUB, 3'b101, 'h16C);
		// Two stalled cycles with a misprediction in the second
		add_entry(enc_r(7'h00, 5'd28, 5'd27, F3_ADD_SUB, 5'd26), 'h160, 4'b0100,
			0, 0, ALU_ADD, 3'b100, 0);
		add_entry(enc_b(13'd16, 5'd5, 5'd1, F3_BEQ), 'h164, 4'b0100,
			0, 16, ALU_SUB, 3'b111, 'h174);
		add_entry(enc_r(7'h00, 5'd31, 5'd30, F3_OR, 5'd29), 'h168, 4'b0000,
			0, 0, ALU_OR, 3'b100, 0);
		add_entry(enc_i(12'd5, 5'd7, F3_SLL, 5'd3, OPC_I), 'h16C, 4'b0000,
			0, 5, ALU_SLL, 3'b100, 0);
		add_entry(enc_r(7'h00, 5'd9, 5'd8, F3_AND, 5'd7), 'h170, 4'b0000,
			0, 0, ALU_AND, 3'b100, 0);
		add_entry(enc_r(7'h00, 5'd4, 5'd1, F3_SLT, 5'd10), 'h174, 4'b0000,
			0, 0, ALU_SLT, 3'b100, 0);
		add_entry(enc_r(7'h00, 5'd4, 5'd3, F3_SRL_SRA, 5'd11), 'h178, 4'b0000,
			0, 0, ALU_SRL, 3'b100, 0);
		add_entry(enc_b(13'd16, 5'd1, 5'd2, F3_BLTU), 'h17C, 4'b1000,
			0, 16, ALU_SUB, 3'b101, 'h18C);
		add_entry(enc_b(13'd16, 5'd1, 5'd2, F3_BLT), 'h180, 4'b1000,
			0, 16, ALU_SUB, 3'b111, 'h190);
		// BNE taken and BGEU not taken on the signed and unsigned edges
		add_entry(enc_b(13'd16, 5'd4, 5'd3, F3_BNE), 'h184, 4'b1000,
			0, 16, ALU_SUB, 3'b101, 'h194);
		add_entry(enc_b(13'd16, 5'd3, 5'd4, F3_BGEU), 'h188, 4'b0000,
			0, 16, ALU_SUB, 3'b101, 'h198);
	endtask

	// Fields of addi x0,x0,0 with zero data
	task automatic expect_bubble();
		exp_rs1_data = '0;
		exp_rs2_data = '0;
		exp_imm      = '0;
		exp_pc       = '0;
		exp_opcode   = INSTR_NOP[6:0];
		exp_func3    = INSTR_NOP[14:12];
		exp_alu      = ALU_ADD;
		exp_rs1      = INSTR_NOP[19:15];
		exp_rs2      = INSTR_NOP[24:20];
		exp_rd       = INSTR_NOP[11:7];
	endtask

	// Next ID/EX contents with stall hold and flush bubble
	task automatic update_expected(input entry_t e);
		if (!e.stall) begin
			if (e.flush) begin
				expect_bubble();
			end else begin
				exp_opcode   = e.instr[6:0];
				exp_func3    = e.instr[14:12];
				exp_rs1      = e.instr[19:15];
				exp_rs2      = e.instr[24:20];
				exp_rd       = e.instr[11:7];
				exp_imm      = e.imm;
				exp_alu      = e.alu;
				exp_pc       = e.pc;
				exp_rs1_data = e.re ? model[e.instr[19:15]] : '0; // Never forwarded
				exp_rs2_data = e.re ? model[e.instr[24:20]] : '0;
			end
		end
	endtask

	task automatic check_registered();
		compare(rs1_data_q, exp_rs1_data, "o_rs1_data");
		compare(rs2_data_q, exp_rs2_data, "o_rs2_data");
		compare(imm_q, exp_imm, "o_imm_data");
		compare(pc_q, exp_pc, "o_pc");
		compare(32'(opcode_q), 32'(exp_opcode), "o_opcode");
		compare(32'(func3_q), 32'(exp_func3), "o_func3");
		compare(32'(alu_q), 32'(exp_alu), "o_alu_ctrl");
		compare(32'(rs1_q), 32'(exp_rs1), "o_rs1");
		compare(32'(rs2_q), 32'(exp_rs2), "o_rs2");
		compare(32'(rd_q), 32'(exp_rd), "o_rd");
	endtask

	task automatic check_comb(input entry_t e);
		compare(32'(flush), 32'(e.flush), $sformatf("o_flush at pc %h", e.pc));
		compare(32'(stall_out), 32'(e.stall), $sformatf("o_stall at pc %h", e.pc));
		if (e.tgt_chk) begin
			compare(branch_pc, e.tgt, $sformatf("o_branch_pc at pc %h", e.pc));
		end
	endtask

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if ((max_cycles != 0) && (cycles > max_cycles)) begin
			$display("Timeout: run went past %0d clock cycles", max_cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		instr      = INSTR_NOP;
		pc         = '0;
		wr         = 1'b0;
		wr_rd      = '0;
		write_data = '0;
		prediction = 1'b0;
		stall      = 1'b0;
		fwd_rs1    = 1'b0;
		fwd_rs2    = 1'b0;
		ex_result  = '0;
		errors     = 0;
		cycles     = 0;
		max_cycles = 0;
		void'($urandom(26));
		expect_bubble();
		build_table();
		max_cycles = tbl.size() + NUM_REGS + 50;

		@(posedge rst_n);
		@(negedge clk);
		check_registered(); // Reset contents

		// Write all 32 registers and give x0 a nonzero value that must not stick
		for (int r = 0; r < NUM_REGS; r++) begin
			@(posedge clk);
			val = $urandom();
			case (r)
				1: val = 32'h8000_0000;
				2: val = 32'h7FFF_FFFF;
				3: val = 32'hFFFF_FFFF;
				4: val = 32'h0000_0001;
				5: val = 32'h8000_0000; // Equal to x1
				6: val = 32'h0000_1003; // Odd JALR base
				default: ;
			endcase
			wr         <= 1'b1;
			wr_rd      <= 5'(r);
			write_data <= (r == 0) ? (val | 32'd1) : val;
			model[5'(r)] = (r == 0) ? '0 : val;
		end

		// Registered results trail the comb checks by one edge
		for (int k = 0; k < tbl.size(); k++) begin
			@(posedge clk);
			wr         <= 1'b0;
			instr      <= tbl[k].instr;
			pc         <= tbl[k].pc;
			prediction <= tbl[k].pred;
			stall      <= tbl[k].stall;
			fwd_rs1    <= tbl[k].fwd1;
			fwd_rs2    <= tbl[k].fwd2;
			ex_result  <= tbl[k].ex;
			@(negedge clk);
			check_registered();
			check_comb(tbl[k]);
			update_expected(tbl[k]);
		end
		@(posedge clk);
		instr      <= INSTR_NOP;
		prediction <= 1'b0;
		stall      <= 1'b0;
		fwd_rs1    <= 1'b0;
		fwd_rs2    <= 1'b0;
		@(negedge clk);
		check_registered(); // Last entry

		$display("Checks done over %0d entries, %0d errors", tbl.size(), errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: sources.f
design/rv_decode_pkg.sv
design/reg_file.sv
design/instr_decoder.sv
design/branch_resolve.sv
design/decode_stage.sv
tb/clk_rst_gen.sv
tb/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# Compile the decode stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_decode_stage -f sources.f \
	-o sim_decode > build.log 2>&1 &&
./obj_dir/sim_decode > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log &&
{ echo "Result: failing checks found in sim.log"; exit 1; } ||
{ echo "Result: no failing checks in sim.log"; exit 0; }
